/* include/trcv_config.svh */
`ifndef TRCV_CONFIG_SVH
`define TRCV_CONFIG_SVH

`define TRCV_CORR_CHANNELS  2
`define TRCV_ADC_W          4       // Signed ADC sample
`define TRCV_ACC_W          20
`define TRCV_ID             32'h5452_4356

// Reset values of the time scale
`define TRCV_EPOCH_LEN_RST  16'd63
`define TRCV_EPOCHS_SEC_RST 16'd9

// Word addresses
`define TRCV_A_ID           8'h00
`define TRCV_A_CTRL         8'h01
`define TRCV_A_EPOCH_LEN    8'h02
`define TRCV_A_EPOCHS_SEC   8'h03
`define TRCV_A_TIME         8'h04
`define TRCV_A_IRQ_STAT     8'h05
`define TRCV_A_IRQ_MASK     8'h06
`define TRCV_A_CH_BASE      8'h10   // 4 words per channel

`endif

/* hdl/trcv_pkg.sv */
`default_nettype none

`include "trcv_config.svh"

package trcv_pkg;

    // CPU register strobes
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [15:0] epoch_len;     // Samples per epoch minus one
        logic [15:0] epochs_sec;    // Epochs per second minus one
        logic        pps_sync;
    } ts_cfg_t;

    typedef struct packed {
        logic [31:0] phase_step;
        logic [31:0] code;
    } ch_cfg_t;

    typedef struct packed {
        logic [15:0] seconds;
        logic [15:0] epoch;
        logic [15:0] sample;
    } time_t;

    typedef struct packed {
        logic signed [`TRCV_ACC_W-1:0] i;
        logic signed [`TRCV_ACC_W-1:0] q;
    } corr_res_t;

endpackage

`default_nettype wire

/* hdl/fix_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module fix_latch #(
    parameter type payload_t = logic
) (
    input  logic     adc,
    input  logic     rst,
    input  logic     fix_pulse,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge adc) begin
        if (rst) begin
            q <= '0;
        end else if (fix_pulse) begin
            q <= d;     // Snapshot of this fix
        end
    end

endmodule

`default_nettype wire

/* hdl/time_scale.sv */
`timescale 1ns/1ns
`default_nettype none

module time_scale
    import trcv_pkg::*;
(
    input  logic    adc,
    input  logic    rst,
    input  ts_cfg_t cfg,
    input  logic    pps_in,
    output logic    epoch_pulse,
    output logic    pps_out,
    output time_t   time_out
);

    logic pps_d;
    logic pps_hit;  // Rising edge seen, acted on at the next edge
    logic sec_wrap;

    assign epoch_pulse = (time_out.sample == cfg.epoch_len);
    assign sec_wrap    = epoch_pulse && (time_out.epoch == cfg.epochs_sec);

    always_ff @(posedge adc) begin
        if (rst) begin
            pps_d   <= 1'b0;
            pps_hit <= 1'b0;
        end else begin
            pps_d   <= pps_in;
            pps_hit <= cfg.pps_sync & pps_in & ~pps_d;
        end
    end

    always_ff @(posedge adc) begin
        if (rst) begin
            time_out <= '0;
            pps_out  <= 1'b0;
        end else begin
            pps_out <= 1'b0;
            if (pps_hit) begin
                // Realign to a fresh second
                time_out.sample  <= '0;
                time_out.epoch   <= '0;
                time_out.seconds <= time_out.seconds + 16'd1;
                pps_out          <= 1'b1;
            end else if (epoch_pulse) begin
                time_out.sample <= '0;
                if (sec_wrap) begin
                    time_out.epoch   <= '0;
                    time_out.seconds <= time_out.seconds + 16'd1;
                    pps_out          <= 1'b1;
                end else begin
                    time_out.epoch <= time_out.epoch + 16'd1;
                end
            end else begin
                time_out.sample <= time_out.sample + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/corr_ch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "trcv_config.svh"

module corr_ch
    import trcv_pkg::*;
(
    input  logic                          adc,
    input  logic                          rst,
    input  ch_cfg_t                       cfg,
    input  logic signed [`TRCV_ADC_W-1:0] adc_data,
    input  logic [4:0]                    sample_idx,
    input  logic                          epoch_pulse,
    output corr_res_t                     res
);

    localparam int EXT_W = `TRCV_ACC_W - `TRCV_ADC_W;

    logic [31:0]                   phase;
    logic                          cos_pos;
    logic                          sin_pos;
    logic                          chip;
    logic signed [`TRCV_ACC_W-1:0] s_ext;
    logic signed [`TRCV_ACC_W-1:0] s_wiped;
    logic signed [`TRCV_ACC_W-1:0] i_term;
    logic signed [`TRCV_ACC_W-1:0] q_term;
    logic signed [`TRCV_ACC_W-1:0] acc_i;
    logic signed [`TRCV_ACC_W-1:0] acc_q;

    // Quadrant signs from the top two phase bits
    assign cos_pos = ~(phase[31] ^ phase[30]);
    assign sin_pos = ~phase[31];

    assign chip    = cfg.code[sample_idx];
    assign s_ext   = {{EXT_W{adc_data[`TRCV_ADC_W-1]}}, adc_data};
    assign s_wiped = chip ? -s_ext : s_ext;    // Code wipe-off
    assign i_term  = cos_pos ? s_wiped : -s_wiped;
    assign q_term  = sin_pos ? s_wiped : -s_wiped;

    always_ff @(posedge adc) begin
        if (rst) begin
            phase <= '0;
            acc_i <= '0;
            acc_q <= '0;
        end else begin
            phase <= phase + cfg.phase_step;
            if (epoch_pulse) begin
                acc_i <= '0;
                acc_q <= '0;
            end else begin
                acc_i <= acc_i + i_term;
                acc_q <= acc_q + q_term;
            end
        end
    end

    // Dump includes the last sample of the epoch
    always_ff @(posedge adc) begin
        if (epoch_pulse) begin
            res.i <= acc_i + i_term;
            res.q <= acc_q + q_term;
        end
    end

endmodule

`default_nettype wire

/* hdl/trcv_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "trcv_config.svh"

module trcv_regs
    import trcv_pkg::*;
(
    input  logic        adc,
    input  logic        rst,
    input  bus_req_t    req,
    output logic [31:0] rdata,
    input  logic        fix_pulse,
    input  time_t       fix_time,
    input  corr_res_t   fix_res [`TRCV_CORR_CHANNELS],
    output ts_cfg_t     ts_cfg,
    output ch_cfg_t     ch_cfg [`TRCV_CORR_CHANNELS],
    output logic        irq
);

    localparam int EXT_W = 32 - `TRCV_ACC_W;

    logic        lock;
    logic        irq_stat;
    logic        irq_mask;
    logic [31:0] rd_mux;

    always_ff @(posedge adc) begin
        if (rst) begin
            lock                <= 1'b0;
            ts_cfg.epoch_len    <= `TRCV_EPOCH_LEN_RST;
            ts_cfg.epochs_sec   <= `TRCV_EPOCHS_SEC_RST;
            ts_cfg.pps_sync     <= 1'b0;
            irq_mask            <= 1'b0;
            for (int ch = 0; ch < `TRCV_CORR_CHANNELS; ch++) begin
                ch_cfg[ch] <= '0;
            end
        end else if (req.wr) begin
            case (req.addr)
                `TRCV_A_CTRL: begin
                    lock            <= lock | req.wdata[0];   // Sticky until reset
                    ts_cfg.pps_sync <= req.wdata[1];
                end
                `TRCV_A_EPOCH_LEN: begin
                    if (!lock) begin
                        ts_cfg.epoch_len <= req.wdata[15:0];
                    end
                end
                `TRCV_A_EPOCHS_SEC: begin
                    if (!lock) begin
                        ts_cfg.epochs_sec <= req.wdata[15:0];
                    end
                end
                `TRCV_A_IRQ_MASK: irq_mask <= req.wdata[0];
                default: ;
            endcase
            for (int ch = 0; ch < `TRCV_CORR_CHANNELS; ch++) begin
                if (!lock && req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch)) begin
                    ch_cfg[ch].phase_step <= req.wdata;
                end
                if (!lock && req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch + 1)) begin
                    ch_cfg[ch].code <= req.wdata;
                end
            end
        end
    end

    // Fix wins over a clear in the same cycle
    always_ff @(posedge adc) begin
        if (rst) begin
            irq_stat <= 1'b0;
        end else if (fix_pulse) begin
            irq_stat <= 1'b1;
        end else if (req.wr && req.addr == `TRCV_A_IRQ_STAT && req.wdata[0]) begin
            irq_stat <= 1'b0;
        end
    end

    assign irq = irq_stat & irq_mask;

    always_comb begin
        rd_mux = '0;
        case (req.addr)
            `TRCV_A_ID:         rd_mux = `TRCV_ID;
            `TRCV_A_CTRL:       rd_mux = {30'd0, ts_cfg.pps_sync, lock};
            `TRCV_A_EPOCH_LEN:  rd_mux = {16'd0, ts_cfg.epoch_len};
            `TRCV_A_EPOCHS_SEC: rd_mux = {16'd0, ts_cfg.epochs_sec};
            // Seconds and epoch truncated to 8 bits each
            `TRCV_A_TIME: rd_mux = {fix_time.seconds[7:0], fix_time.epoch[7:0], fix_time.sample};
            `TRCV_A_IRQ_STAT:   rd_mux = {31'd0, irq_stat};
            `TRCV_A_IRQ_MASK:   rd_mux = {31'd0, irq_mask};
            default: ;
        endcase
        for (int ch = 0; ch < `TRCV_CORR_CHANNELS; ch++) begin
            if (req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch)) begin
                rd_mux = ch_cfg[ch].phase_step;
            end
            if (req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch + 1)) begin
                rd_mux = ch_cfg[ch].code;
            end
            if (req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch + 2)) begin
                rd_mux = {{EXT_W{fix_res[ch].i[`TRCV_ACC_W-1]}}, fix_res[ch].i};
            end
            if (req.addr == 8'(`TRCV_A_CH_BASE + 4 * ch + 3)) begin
                rd_mux = {{EXT_W{fix_res[ch].q[`TRCV_ACC_W-1]}}, fix_res[ch].q};
            end
        end
    end

    always_ff @(posedge adc) begin
        if (req.rd) begin
            rdata <= rd_mux;    // Held until next read
        end
    end

endmodule

`default_nettype wire

/* hdl/trcv.sv */
`timescale 1ns/1ns
`default_nettype none

`include "trcv_config.svh"

module trcv
    import trcv_pkg::*;
(
    input  logic                          adc,
    input  logic                          rst,
    input  bus_req_t                      req,
    output logic [31:0]                   rdata,
    input  logic signed [`TRCV_ADC_W-1:0] adc_data,
    input  logic                          pps_in,
    output logic                          pps_out,
    output logic                          irq
);

    ts_cfg_t   ts_cfg;
    ch_cfg_t   ch_cfg  [`TRCV_CORR_CHANNELS];
    corr_res_t ch_res  [`TRCV_CORR_CHANNELS];
    corr_res_t fix_res [`TRCV_CORR_CHANNELS];
    time_t     time_now;
    time_t     fix_time;
    logic      epoch_pulse;
    logic      fix_pulse;

    always_ff @(posedge adc) begin
        if (rst) begin
            fix_pulse <= 1'b0;
        end else begin
            fix_pulse <= epoch_pulse;   // Dumps are valid here
        end
    end

    trcv_regs i_regs (
        .adc       (adc),
        .rst       (rst),
        .req       (req),
        .rdata     (rdata),
        .fix_pulse (fix_pulse),
        .fix_time  (fix_time),
        .fix_res   (fix_res),
        .ts_cfg    (ts_cfg),
        .ch_cfg    (ch_cfg),
        .irq       (irq)
    );

    time_scale i_time_scale (
        .adc         (adc),
        .rst         (rst),
        .cfg         (ts_cfg),
        .pps_in      (pps_in),
        .epoch_pulse (epoch_pulse),
        .pps_out     (pps_out),
        .time_out    (time_now)
    );

    fix_latch #(.payload_t(time_t)) i_time_latch (
        .adc       (adc),
        .rst       (rst),
        .fix_pulse (fix_pulse),
        .d         (time_now),
        .q         (fix_time)
    );

    for (genvar ch = 0; ch < `TRCV_CORR_CHANNELS; ch++) begin : g_ch
        corr_ch i_corr (
            .adc         (adc),
            .rst         (rst),
            .cfg         (ch_cfg[ch]),
            .adc_data    (adc_data),
            .sample_idx  (time_now.sample[4:0]),
            .epoch_pulse (epoch_pulse),
            .res         (ch_res[ch])
        );

        fix_latch #(.payload_t(corr_res_t)) i_res_latch (
            .adc       (adc),
            .rst       (rst),
            .fix_pulse (fix_pulse),
            .d         (ch_res[ch]),
            .q         (fix_res[ch])
        );
    end

endmodule

`default_nettype wire

/* test/trcv_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module trcv_checker (
    input logic adc,
    input logic rst,
    input logic epoch_pulse,
    input logic fix_pulse,
    input logic irq_mask,
    input logic irq,
    input logic pps_out
);

    int failures = 0;

    a_epoch_width: assert property (@(posedge adc) disable iff (rst)
        epoch_pulse |=> !epoch_pulse)
        else begin
            failures++;
            $error("epoch_pulse wider than one cycle");
        end

    a_fix_width: assert property (@(posedge adc) disable iff (rst)
        fix_pulse |=> !fix_pulse)
        else begin
            failures++;
            $error("fix_pulse wider than one cycle");
        end

    a_fix_follows: assert property (@(posedge adc) disable iff (rst)
        epoch_pulse |=> fix_pulse)
        else begin
            failures++;
            $error("fix_pulse missing after epoch_pulse");
        end

    // Status is set by every fix, so irq then follows the mask
    a_irq_masked: assert property (@(posedge adc) disable iff (rst)
        fix_pulse |=> (irq == irq_mask))
        else begin
            failures++;
            $error("irq does not follow the mask after a fix");
        end

    a_pps_reset: assert property (@(posedge adc) rst |=> !pps_out)
        else begin
            failures++;
            $error("pps_out high during reset");
        end

endmodule

bind trcv trcv_checker i_checker (
    .adc         (adc),
    .rst         (rst),
    .epoch_pulse (epoch_pulse),
    .fix_pulse   (fix_pulse),
    .irq_mask    (i_regs.irq_mask),
    .irq         (irq),
    .pps_out     (pps_out)
);

`default_nettype wire

/* test/trcv_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "trcv_config.svh"

module trcv_tb
    import trcv_pkg::*;
();

    localparam int NCH     = `TRCV_CORR_CHANNELS;
    localparam int EXT_W   = `TRCV_ACC_W - `TRCV_ADC_W;
    localparam int TIMEOUT = 20000;

    logic                          adc;
    logic                          rst;
    bus_req_t                      req;
    logic [31:0]                   rdata;
    logic signed [`TRCV_ADC_W-1:0] adc_data;
    logic                          pps_in;
    logic                          pps_out;
    logic                          irq;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // Reference model state
    logic        m_lock;
    logic        m_sync;
    logic        m_mask;
    logic        m_stat;
    logic        m_fix;
    logic        m_pps_d;
    logic        m_pps_hit;
    logic        m_pps_out;
    logic [15:0] m_elen;
    logic [15:0] m_esec;
    logic [15:0] m_sample;
    logic [15:0] m_epoch;
    logic [15:0] m_sec;
    logic [15:0] m_fsample;
    logic [15:0] m_fepoch;
    logic [15:0] m_fsec;
    logic [31:0] m_rdata;
    logic [31:0] m_step  [NCH];
    logic [31:0] m_code  [NCH];
    logic [31:0] m_phase [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_acc_i  [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_acc_q  [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_dump_i [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_dump_q [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_fi     [NCH];
    logic signed [`TRCV_ACC_W-1:0] m_fq     [NCH];

    trcv i_dut (
        .adc      (adc),
        .rst      (rst),
        .req      (req),
        .rdata    (rdata),
        .adc_data (adc_data),
        .pps_in   (pps_in),
        .pps_out  (pps_out),
        .irq      (irq)
    );

    initial begin
        adc = 1'b0;
        forever #2 adc = ~adc;
    end

    function automatic int channel_of(input logic [7:0] a);
        int off;
        off = int'(a) - int'(`TRCV_A_CH_BASE);
        if (off < 0 || off >= 4 * NCH) begin
            return -1;
        end
        return off / 4;
    endfunction

    function automatic logic [7:0] word_addr(input int c, input int k);
        return 8'(int'(`TRCV_A_CH_BASE) + 4 * c + k);
    endfunction

    function automatic string reg_name(input logic [7:0] a);
        int c;
        c = channel_of(a);
        if (c >= 0) begin
            case (a[1:0])
                2'd0:    return $sformatf("CH%0d_PHASE_STEP", c);
                2'd1:    return $sformatf("CH%0d_CODE", c);
                2'd2:    return $sformatf("CH%0d_I", c);
                default: return $sformatf("CH%0d_Q", c);
            endcase
        end
        case (a)
            `TRCV_A_ID:         return "ID";
            `TRCV_A_CTRL:       return "CTRL";
            `TRCV_A_EPOCH_LEN:  return "EPOCH_LEN";
            `TRCV_A_EPOCHS_SEC: return "EPOCHS_SEC";
            `TRCV_A_TIME:       return "TIME";
            `TRCV_A_IRQ_STAT:   return "IRQ_STAT";
            `TRCV_A_IRQ_MASK:   return "IRQ_MASK";
            default:            return $sformatf("ADDR_%h", a);
        endcase
    endfunction

    // Register view of the model, from its state before the edge
    function automatic logic [31:0] model_read(input logic [7:0] a);
        int c;
        c = channel_of(a);
        if (c >= 0) begin
            case (a[1:0])
                2'd0:    return m_step[c];
                2'd1:    return m_code[c];
                2'd2:    return 32'(m_fi[c]);
                default: return 32'(m_fq[c]);
            endcase
        end
        case (a)
            `TRCV_A_ID:         return `TRCV_ID;
            `TRCV_A_CTRL:       return {30'd0, m_sync, m_lock};
            `TRCV_A_EPOCH_LEN:  return {16'd0, m_elen};
            `TRCV_A_EPOCHS_SEC: return {16'd0, m_esec};
            `TRCV_A_TIME:       return {m_fsec[7:0], m_fepoch[7:0], m_fsample};
            `TRCV_A_IRQ_STAT:   return {31'd0, m_stat};
            `TRCV_A_IRQ_MASK:   return {31'd0, m_mask};
            default:            return 32'd0;
        endcase
    endfunction

    always @(posedge adc) begin : model
        logic                          ep;
        logic signed [`TRCV_ACC_W-1:0] s;
        logic signed [`TRCV_ACC_W-1:0] it;
        logic signed [`TRCV_ACC_W-1:0] qt;
        int                            c;
        ep = (m_sample == m_elen);
        if (rst) begin
            m_lock    <= 1'b0;
            m_sync    <= 1'b0;
            m_mask    <= 1'b0;
            m_stat    <= 1'b0;
            m_fix     <= 1'b0;
            m_pps_d   <= 1'b0;
            m_pps_hit <= 1'b0;
            m_pps_out <= 1'b0;
            m_elen    <= `TRCV_EPOCH_LEN_RST;
            m_esec    <= `TRCV_EPOCHS_SEC_RST;
            m_sample  <= '0;
            m_epoch   <= '0;
            m_sec     <= '0;
            m_fsample <= '0;
            m_fepoch  <= '0;
            m_fsec    <= '0;
            for (int ch = 0; ch < NCH; ch++) begin
                m_step[ch]  <= '0;
                m_code[ch]  <= '0;
                m_phase[ch] <= '0;
                m_acc_i[ch] <= '0;
                m_acc_q[ch] <= '0;
                m_fi[ch]    <= '0;
                m_fq[ch]    <= '0;
            end
        end else begin
            for (int ch = 0; ch < NCH; ch++) begin
                s = {{EXT_W{adc_data[`TRCV_ADC_W-1]}}, adc_data};
                if (m_code[ch][m_sample[4:0]]) begin
                    s = -s;
                end
                it = (m_phase[ch][31] == m_phase[ch][30]) ? s : -s;   // Quadrants 0 and 3
                qt = m_phase[ch][31] ? -s : s;                        // Quadrants 0 and 1
                m_phase[ch] <= m_phase[ch] + m_step[ch];
                m_acc_i[ch] <= ep ? '0 : m_acc_i[ch] + it;
                m_acc_q[ch] <= ep ? '0 : m_acc_q[ch] + qt;
                if (ep) begin
                    m_dump_i[ch] <= m_acc_i[ch] + it;
                    m_dump_q[ch] <= m_acc_q[ch] + qt;
                end
                if (m_fix) begin
                    m_fi[ch] <= m_dump_i[ch];
                    m_fq[ch] <= m_dump_q[ch];
                end
            end
            m_pps_d   <= pps_in;
            m_pps_hit <= m_sync & pps_in & ~m_pps_d;
            m_pps_out <= 1'b0;
            if (m_pps_hit) begin
                m_sample  <= '0;
                m_epoch   <= '0;
                m_sec     <= m_sec + 16'd1;
                m_pps_out <= 1'b1;
            end else if (ep) begin
                m_sample <= '0;
                if (m_epoch == m_esec) begin
                    m_epoch   <= '0;
                    m_sec     <= m_sec + 16'd1;
                    m_pps_out <= 1'b1;
                end else begin
                    m_epoch <= m_epoch + 16'd1;
                end
            end else begin
                m_sample <= m_sample + 16'd1;
            end
            m_fix <= ep;
            if (m_fix) begin
                m_fsample <= m_sample;
                m_fepoch  <= m_epoch;
                m_fsec    <= m_sec;
                m_stat    <= 1'b1;
            end else if (req.wr && req.addr == `TRCV_A_IRQ_STAT && req.wdata[0]) begin
                m_stat <= 1'b0;
            end
            if (req.wr) begin
                c = channel_of(req.addr);
                case (req.addr)
                    `TRCV_A_CTRL: begin
                        m_lock <= m_lock | req.wdata[0];
                        m_sync <= req.wdata[1];
                    end
                    `TRCV_A_EPOCH_LEN:  if (!m_lock) m_elen <= req.wdata[15:0];
                    `TRCV_A_EPOCHS_SEC: if (!m_lock) m_esec <= req.wdata[15:0];
                    `TRCV_A_IRQ_MASK:   m_mask <= req.wdata[0];
                    default: ;
                endcase
                if (c >= 0 && !m_lock && req.addr[1:0] == 2'd0) m_step[c] <= req.wdata;
                if (c >= 0 && !m_lock && req.addr[1:0] == 2'd1) m_code[c] <= req.wdata;
            end
            if (req.rd) begin
                m_rdata <= model_read(req.addr);
            end
        end
    end

    always @(posedge adc) begin
        adc_data <= 4'($urandom);
    end

    // Pulse and interrupt outputs against the model every cycle
    always @(negedge adc) begin
        if (!rst) begin
            checks += 2;
            assert (pps_out == m_pps_out) else begin
                errors++;
                $display("Error pps_out got %h expected %h", pps_out, m_pps_out);
            end
            assert (irq == (m_stat & m_mask)) else begin
                errors++;
                $display("Error irq got %h expected %h", irq, m_stat & m_mask);
            end
        end
    end

    task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
        @(posedge adc);
        req.wr    <= 1'b1;
        req.addr  <= a;
        req.wdata <= d;
        @(posedge adc);
        req.wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] a);
        @(posedge adc);
        req.rd   <= 1'b1;
        req.addr <= a;
        @(posedge adc);
        req.rd <= 1'b0;
        @(negedge adc);
        checks++;
        assert (rdata == m_rdata) else begin
            errors++;
            $display("Error %s got %h expected %h", reg_name(a), rdata, m_rdata);
        end
    endtask

    // Returns at the edge where the latches take the fix
    task automatic wait_fix();
        @(negedge adc);
        while (!i_dut.fix_pulse) begin
            @(negedge adc);
        end
        @(posedge adc);
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge adc);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(50316));
        rst      = 1'b1;
        req      = '0;
        adc_data = '0;
        pps_in   = 1'b0;
        repeat (2) @(posedge adc);
        rst <= 1'b0;

        // Short epochs, set before the sample count passes 15
        write_reg(`TRCV_A_EPOCH_LEN, 32'd15);
        write_reg(`TRCV_A_EPOCHS_SEC, 32'd3);
        read_reg(`TRCV_A_ID);
        read_reg(`TRCV_A_CTRL);
        repeat (10) begin
            wait_fix();
            read_reg(`TRCV_A_TIME);
        end

        for (int ch = 0; ch < NCH; ch++) begin
            write_reg(word_addr(ch, 0), $urandom);
            write_reg(word_addr(ch, 1), $urandom);
        end
        repeat (6) begin
            wait_fix();
            for (int ch = 0; ch < NCH; ch++) begin
                read_reg(word_addr(ch, 2));
                read_reg(word_addr(ch, 3));
            end
        end

        write_reg(`TRCV_A_IRQ_MASK, 32'd1);
        wait_fix();
        @(negedge adc);
        checks++;
        assert (irq) else begin
            errors++;
            $display("Error irq got %h expected %h", irq, 1'b1);
        end
        write_reg(`TRCV_A_IRQ_STAT, 32'd1);
        @(negedge adc);
        checks++;
        assert (!irq) else begin
            errors++;
            $display("Error irq got %h expected %h", irq, 1'b0);
        end
        write_reg(`TRCV_A_IRQ_MASK, 32'd0);
        repeat (2) wait_fix();

        write_reg(`TRCV_A_CTRL, 32'd1);
        write_reg(`TRCV_A_EPOCH_LEN, 32'd7);
        read_reg(`TRCV_A_EPOCH_LEN);
        checks++;
        assert (rdata == 32'd15) else begin
            errors++;
            $display("Error EPOCH_LEN got %h expected %h", rdata, 32'd15);
        end
        repeat (3) begin
            wait_fix();
            read_reg(`TRCV_A_TIME);
        end

        write_reg(`TRCV_A_CTRL, 32'd3);
        repeat ($urandom_range(40)) @(posedge adc);
        pps_in <= 1'b1;
        repeat (4) @(posedge adc);
        pps_in <= 1'b0;
        repeat (2) begin
            wait_fix();
            read_reg(`TRCV_A_TIME);
        end

        repeat (4) @(posedge adc);
        errors += i_dut.i_checker.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hdl/trcv_pkg.sv
hdl/fix_latch.sv
hdl/time_scale.sv
hdl/corr_ch.sv
hdl/trcv_regs.sv
hdl/trcv.sv
test/trcv_checker.sv
test/trcv_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the trcv testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trcv_tb -f sim.f -o trcv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/trcv_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
